/* include/burst_bridge_settings.svh */
//--------------------------------------------------------------------------
// Unaligned read-burst bridge settings
// Bus widths, words per line and depth of the pending-read queue
//--------------------------------------------------------------------------
`ifndef BURST_BRIDGE_SETTINGS_SVH
`define BURST_BRIDGE_SETTINGS_SVH

// bus widths
`define BB_DATA_WIDTH        32
`define BB_ADDR_WIDTH        16
`define BB_BURST_WIDTH       5

// a line is 2**BB_LINE_LOG2 words
`define BB_LINE_LOG2         2
`define BB_OUT_BURST_WIDTH   6

// pending-read queue
`define BB_PENDING_DEPTH     8
`define BB_PENDING_PTR_WIDTH 3

`endif

/* source/burst_bridge_pkg.sv */
//--------------------------------------------------------------------------
// Unaligned read-burst bridge types
// Vector types, the pending-read record and the response filter states
//--------------------------------------------------------------------------
`include "burst_bridge_settings.svh"

package burst_bridge_pkg;

    // bus quantities
    typedef logic [`BB_DATA_WIDTH-1:0]      data_t;
    typedef logic [`BB_ADDR_WIDTH-1:0]      addr_t;
    typedef logic [`BB_BURST_WIDTH-1:0]     burst_t;

    // expanded count, also wide enough for the filter beat counter
    typedef logic [`BB_OUT_BURST_WIDTH-1:0] out_burst_t;

    // word position inside a line
    typedef logic [`BB_LINE_LOG2-1:0]       line_offset_t;

    // one outstanding read, oldest field first in beat order
    typedef struct packed {
        line_offset_t lead_beats;
        burst_t       keep_beats;
        line_offset_t trail_beats;
    } pending_read_t;

    // response filter phases
    typedef enum logic [1:0] {
        idle,
        lead,
        keep,
        trail
    } filter_state_e;

endpackage

/* source/burst_aligner.sv */
//--------------------------------------------------------------------------
// Burst aligner
// Rounds a read burst out to whole lines and builds the record that
// tells the response filter which beats to drop
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "burst_bridge_settings.svh"

module burst_aligner (
    input  burst_bridge_pkg::addr_t         address,
    input  burst_bridge_pkg::burst_t        burstcount,
    output burst_bridge_pkg::addr_t         aligned_address,
    output burst_bridge_pkg::out_burst_t    aligned_burstcount,
    output burst_bridge_pkg::pending_read_t record
);

    localparam int line_words = 1 << `BB_LINE_LOG2;

    burst_bridge_pkg::line_offset_t lead_beats;
    burst_bridge_pkg::out_burst_t   span_beats;
    burst_bridge_pkg::out_burst_t   line_count;
    burst_bridge_pkg::out_burst_t   surplus_beats;

    // words before the start word in its line are fetched and dropped
    assign lead_beats      = address[`BB_LINE_LOG2-1:0];
    assign aligned_address = {address[`BB_ADDR_WIDTH-1:`BB_LINE_LOG2], {`BB_LINE_LOG2{1'b0}}};

    // lead words plus requested words, rounded up to whole lines
    assign span_beats = burst_bridge_pkg::out_burst_t'(lead_beats)
                      + burst_bridge_pkg::out_burst_t'(burstcount);

    assign line_count = (span_beats + burst_bridge_pkg::out_burst_t'(line_words - 1))
                      >> `BB_LINE_LOG2;

    assign aligned_burstcount = line_count << `BB_LINE_LOG2;

    // what is left after the last requested word, always under one line
    assign surplus_beats = aligned_burstcount - span_beats;

    always_comb begin
        record.lead_beats  = lead_beats;
        record.keep_beats  = burstcount;
        record.trail_beats = surplus_beats[`BB_LINE_LOG2-1:0];
    end

endmodule

/* source/pending_read_fifo.sv */
//--------------------------------------------------------------------------
// Pending-read queue
// Register-array FIFO holding one record per outstanding read burst
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "burst_bridge_settings.svh"

module pending_read_fifo (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            push,
    input  burst_bridge_pkg::pending_read_t push_record,
    input  logic                            pop,
    output burst_bridge_pkg::pending_read_t head_record,
    output logic                            head_valid,
    output logic                            full
);

    localparam int count_width = $clog2(`BB_PENDING_DEPTH + 1);

    localparam logic [`BB_PENDING_PTR_WIDTH-1:0] last_ptr =
        `BB_PENDING_PTR_WIDTH'(`BB_PENDING_DEPTH - 1);

    localparam logic [count_width-1:0] depth_count = count_width'(`BB_PENDING_DEPTH);

    burst_bridge_pkg::pending_read_t entries [`BB_PENDING_DEPTH];

    logic [`BB_PENDING_PTR_WIDTH-1:0] wr_ptr;
    logic [`BB_PENDING_PTR_WIDTH-1:0] rd_ptr;
    logic [count_width-1:0]           occupancy;

    //----------------------------------------------------------------------
    // storage
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_record;
        end
    end

    //----------------------------------------------------------------------
    // pointers and fill level
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            // a simultaneous push and pop leaves the level unchanged
            if (push && !pop) begin
                occupancy <= occupancy + 1'b1;
            end else if (pop && !push) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

    assign head_record = entries[rd_ptr];
    assign head_valid  = (occupancy != '0);
    assign full        = (occupancy == depth_count);

endmodule

/* source/read_response_filter.sv */
//--------------------------------------------------------------------------
// Read response filter
// Registers each returning beat and passes only the requested words,
// dropping the lead and trail beats of every expanded burst
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module read_response_filter (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            beat_valid,
    input  burst_bridge_pkg::data_t         beat_data,
    input  burst_bridge_pkg::pending_read_t head_record,
    input  logic                            head_valid,
    output logic                            pop,
    output burst_bridge_pkg::data_t         readdata,
    output logic                            readdatavalid
);

    burst_bridge_pkg::filter_state_e state;
    burst_bridge_pkg::filter_state_e state_next;
    burst_bridge_pkg::out_burst_t    beat_count;
    burst_bridge_pkg::out_burst_t    beat_count_next;
    burst_bridge_pkg::pending_read_t active;
    burst_bridge_pkg::pending_read_t active_next;

    logic                    rsp_valid;
    burst_bridge_pkg::data_t rsp_data;
    logic                    last_beat;
    logic                    burst_done;

    //----------------------------------------------------------------------
    // response register
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= beat_valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_data <= beat_data;
    end

    //----------------------------------------------------------------------
    // phase tracking
    //----------------------------------------------------------------------
    assign last_beat = rsp_valid && (beat_count == burst_bridge_pkg::out_burst_t'(1));

    always_comb begin
        state_next      = state;
        beat_count_next = beat_count;
        active_next     = active;
        pop             = 1'b0;
        burst_done      = 1'b0;

        case (state)
            burst_bridge_pkg::idle: begin
                burst_done = 1'b1;
            end
            burst_bridge_pkg::lead: begin
                if (last_beat) begin
                    state_next      = burst_bridge_pkg::keep;
                    beat_count_next = burst_bridge_pkg::out_burst_t'(active.keep_beats);
                end else if (rsp_valid) begin
                    beat_count_next = beat_count - 1'b1;
                end
            end
            burst_bridge_pkg::keep: begin
                if (last_beat && (active.trail_beats != '0)) begin
                    state_next      = burst_bridge_pkg::trail;
                    beat_count_next = burst_bridge_pkg::out_burst_t'(active.trail_beats);
                end else if (last_beat) begin
                    burst_done = 1'b1;
                end else if (rsp_valid) begin
                    beat_count_next = beat_count - 1'b1;
                end
            end
            default: begin
                if (last_beat) begin
                    burst_done = 1'b1;
                end else if (rsp_valid) begin
                    beat_count_next = beat_count - 1'b1;
                end
            end
        endcase

        // take the next record straight away so bursts run back to back
        if (burst_done) begin
            if (head_valid) begin
                pop         = 1'b1;
                active_next = head_record;
                if (head_record.lead_beats != '0) begin
                    state_next      = burst_bridge_pkg::lead;
                    beat_count_next = burst_bridge_pkg::out_burst_t'(head_record.lead_beats);
                end else begin
                    state_next      = burst_bridge_pkg::keep;
                    beat_count_next = burst_bridge_pkg::out_burst_t'(head_record.keep_beats);
                end
            end else begin
                state_next = burst_bridge_pkg::idle;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= burst_bridge_pkg::idle;
            beat_count <= '0;
            active     <= '0;
        end else begin
            state      <= state_next;
            beat_count <= beat_count_next;
            active     <= active_next;
        end
    end

    // only beats of the keep phase reach the host
    assign readdatavalid = rsp_valid && (state == burst_bridge_pkg::keep);
    assign readdata      = rsp_data;

endmodule

/* source/unaligned_burst_bridge.sv */
//--------------------------------------------------------------------------
// Unaligned read-burst expansion bridge
// Widens host reads to whole memory lines and hands back only the
// requested words, with up to a queue depth of bursts in flight
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module unaligned_burst_bridge (
    input  logic                         clk,
    input  logic                         reset,

    // host side
    input  logic                         s0_read,
    input  burst_bridge_pkg::addr_t      s0_address,
    input  burst_bridge_pkg::burst_t     s0_burstcount,
    output logic                         s0_waitrequest,
    output burst_bridge_pkg::data_t      s0_readdata,
    output logic                         s0_readdatavalid,

    // memory side
    output logic                         m0_read,
    output burst_bridge_pkg::addr_t      m0_address,
    output burst_bridge_pkg::out_burst_t m0_burstcount,
    input  logic                         m0_waitrequest,
    input  burst_bridge_pkg::data_t      m0_readdata,
    input  logic                         m0_readdatavalid
);

    burst_bridge_pkg::pending_read_t issue_record;
    burst_bridge_pkg::pending_read_t head_record;

    logic push;
    logic pop;
    logic head_valid;
    logic queue_full;

    //----------------------------------------------------------------------
    // command path
    //----------------------------------------------------------------------
    burst_aligner aligner (
        .address            (s0_address),
        .burstcount         (s0_burstcount),
        .aligned_address    (m0_address),
        .aligned_burstcount (m0_burstcount),
        .record             (issue_record)
    );

    // no new read goes out until the queue has room for its record
    assign m0_read        = s0_read && !queue_full;
    assign s0_waitrequest = (queue_full && s0_read) ? 1'b1 : m0_waitrequest;
    assign push           = s0_read && !s0_waitrequest;

    pending_read_fifo pending (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_record (issue_record),
        .pop         (pop),
        .head_record (head_record),
        .head_valid  (head_valid),
        .full        (queue_full)
    );

    //----------------------------------------------------------------------
    // response path
    //----------------------------------------------------------------------
    read_response_filter filter (
        .clk           (clk),
        .reset         (reset),
        .beat_valid    (m0_readdatavalid),
        .beat_data     (m0_readdata),
        .head_record   (head_record),
        .head_valid    (head_valid),
        .pop           (pop),
        .readdata      (s0_readdata),
        .readdatavalid (s0_readdatavalid)
    );

endmodule

/* tests/unaligned_burst_bridge_sva.sv */
//--------------------------------------------------------------------------
// Bridge assertions
// Queue flow control and reset behavior of the unaligned burst bridge
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module unaligned_burst_bridge_sva (
    input logic clk,
    input logic reset,
    input logic m0_read,
    input logic queue_full,
    input logic push,
    input logic pop,
    input logic head_valid,
    input logic s0_readdatavalid
);

    int violations = 0;

    // no command reaches memory without room for its record
    read_blocked_when_full: assert property (@(posedge clk) disable iff (reset)
        queue_full |-> !m0_read)
        else begin
            $error("m0_read high while the pending queue is full");
            violations++;
        end

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(push && queue_full))
        else begin
            $error("record pushed into a full pending queue");
            violations++;
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> head_valid)
        else begin
            $error("record popped from an empty pending queue");
            violations++;
        end

    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !s0_readdatavalid)
        else begin
            $error("s0_readdatavalid high right after reset");
            violations++;
        end

endmodule

bind unaligned_burst_bridge unaligned_burst_bridge_sva checks (
    .clk              (clk),
    .reset            (reset),
    .m0_read          (m0_read),
    .queue_full       (queue_full),
    .push             (push),
    .pop              (pop),
    .head_valid       (head_valid),
    .s0_readdatavalid (s0_readdatavalid)
);

/* tests/tb_unaligned_burst_bridge.sv */
//--------------------------------------------------------------------------
// Testbench for the unaligned read-burst bridge
// Issues bursts from the test data file against a slave memory model
// and checks the filtered read data against a scoreboard
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "burst_bridge_settings.svh"

module tb_unaligned_burst_bridge;

    localparam int line_words = 1 << `BB_LINE_LOG2;

    // one read command, count is widened so a data file entry fits
    typedef struct packed {
        burst_bridge_pkg::addr_t address;
        logic [7:0]              count;
    } read_cmd_t;

    logic                         clk = 1'b0;
    logic                         reset = 1'b1;
    logic                         s0_read = 1'b0;
    burst_bridge_pkg::addr_t      s0_address = '0;
    burst_bridge_pkg::burst_t     s0_burstcount = '0;
    logic                         s0_waitrequest;
    burst_bridge_pkg::data_t      s0_readdata;
    logic                         s0_readdatavalid;
    logic                         m0_read;
    burst_bridge_pkg::addr_t      m0_address;
    burst_bridge_pkg::out_burst_t m0_burstcount;
    logic                         m0_waitrequest = 1'b0;
    burst_bridge_pkg::data_t      m0_readdata = '0;
    logic                         m0_readdatavalid = 1'b0;

    logic [23:0]             stim_words [64];
    read_cmd_t               mem_cmds [$];
    burst_bridge_pkg::data_t expected [$];
    read_cmd_t               beat_cmd = '0;
    logic [31:0]             lfsr_state = 32'h3142_cbe8;
    int                      num_bursts = 0;
    int                      total_words = 0;
    int                      received = 0;
    logic                    loaded = 1'b0;
    logic                    hold_data = 1'b1;
    logic                    stall_seen = 1'b0;

    always #5 clk = ~clk;

    unaligned_burst_bridge DUT (
        .clk              (clk),
        .reset            (reset),
        .s0_read          (s0_read),
        .s0_address       (s0_address),
        .s0_burstcount    (s0_burstcount),
        .s0_waitrequest   (s0_waitrequest),
        .s0_readdata      (s0_readdata),
        .s0_readdatavalid (s0_readdatavalid),
        .m0_read          (m0_read),
        .m0_address       (m0_address),
        .m0_burstcount    (m0_burstcount),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid)
    );

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic taken;
        taken = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (taken ? 32'h8020_0003 : 32'h0);
        return taken;
    endfunction

    function automatic burst_bridge_pkg::data_t model_word(burst_bridge_pkg::addr_t a);
        return {16'h0, a} ^ 32'hA5A5_0000;
    endfunction

    // lines from the one holding the first word to the one holding the last
    function automatic int expected_count(burst_bridge_pkg::addr_t a, int c);
        int first_line;
        int last_line;
        first_line = int'(a) / line_words;
        last_line  = (int'(a) + c - 1) / line_words;
        return (last_line - first_line + 1) * line_words;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare(string name, logic [31:0] actual, logic [31:0] wanted);
        if (actual !== wanted) begin
            stop_on_error($sformatf("Mismatch at %0t: %s = %h, expected %h",
                                    $time, name, actual, wanted));
        end
    endtask

    task automatic issue_read(read_cmd_t cmd);
        s0_read       = 1'b1;
        s0_address    = cmd.address;
        s0_burstcount = burst_bridge_pkg::burst_t'(cmd.count);
        @(negedge clk);
        while (s0_waitrequest) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        s0_read = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // slave memory model, in-order beats with random gaps
    //----------------------------------------------------------------------
    always begin
        @(posedge clk);
        #1;
        m0_readdatavalid = 1'b0;
        m0_waitrequest   = hold_data ? 1'b0 : (lfsr_bit() & lfsr_bit());
        if (!hold_data && (beat_cmd.count != 0 || mem_cmds.size() != 0)) begin
            if (lfsr_bit() | lfsr_bit()) begin
                if (beat_cmd.count == 0) begin
                    beat_cmd = mem_cmds.pop_front();
                end
                m0_readdatavalid = 1'b1;
                m0_readdata      = model_word(beat_cmd.address);
                beat_cmd.address = beat_cmd.address + 1'b1;
                beat_cmd.count   = beat_cmd.count - 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // monitor and scoreboard, sampled mid-cycle
    //----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            compare("m0 accept", m0_read && !m0_waitrequest, s0_read && !s0_waitrequest);
            if (s0_read && !s0_waitrequest) begin
                for (int k = 0; k < int'(s0_burstcount); k++) begin
                    expected.push_back(model_word(s0_address + 16'(k)));
                end
            end
            if (m0_read && !m0_waitrequest) begin
                compare("m0_address[1:0]", m0_address[`BB_LINE_LOG2-1:0], 0);
                compare("m0_address", m0_address, s0_address & ~16'(line_words - 1));
                compare("m0_burstcount", m0_burstcount,
                        expected_count(s0_address, int'(s0_burstcount)));
                mem_cmds.push_back({m0_address, 2'b00, m0_burstcount});
            end
            if (s0_readdatavalid) begin
                if (expected.size() == 0) begin
                    stop_on_error("s0_readdatavalid pulsed with no requested word outstanding");
                end else begin
                    compare("s0_readdata", s0_readdata, expected.pop_front());
                    received++;
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin
        for (int i = 0; i < 64; i++) begin
            stim_words[i] = '0;
        end
        $readmemh("tests/burst_bridge_testdata.txt", stim_words);
        while (num_bursts < 64 && stim_words[num_bursts][7:0] != 0) begin
            total_words += int'(stim_words[num_bursts][7:0]);
            num_bursts++;
        end
        if (num_bursts < 10) begin
            stop_on_error("test data file holds too few bursts to fill the pending queue");
        end
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < num_bursts; i++) begin
            issue_read(read_cmd_t'(stim_words[i]));
        end
        while (received < total_words) begin
            @(negedge clk);
        end
        // extra pulses after the last word are caught by the monitor
        repeat (20) @(negedge clk);
        compare("stall seen", stall_seen, 1'b1);
        if (DUT.checks.violations != 0) begin
            stop_on_error("bound assertions on the bridge reported violations");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    // memory withholds data until the host has been stalled by a full queue
    initial begin : release_data
        int waited;
        waited = 0;
        wait (loaded);
        while (!stall_seen && waited < 400) begin
            @(negedge clk);
            if (!reset && s0_read && s0_waitrequest) begin
                stall_seen = 1'b1;
            end
            waited++;
        end
        repeat (10) @(posedge clk);
        #1;
        hold_data = 1'b0;
    end

    initial begin
        wait (loaded);
        repeat (num_bursts * 200 + 8) @(posedge clk);
        stop_on_error("Timeout: read bursts did not complete within the allowed cycles");
    end

endmodule

/* tests/burst_bridge_testdata.txt */
// columns: aaaa_cc = start word address (hex), burst count (hex, 01 to 10)
// the first ten bursts go out while the memory holds back its read data
0000_04 // aligned line
0010_10 // aligned, longest burst
0020_01 // single beat, offset 0
0021_01 // single beat, offset 1
0022_01 // single beat, offset 2
0023_01 // single beat, offset 3
0041_03 // ends on a line boundary
0046_07 // lead and trail beats
005b_10 // offset 3 with 16 words, widest expansion
0063_02 // crosses a line boundary
0077_05
0080_08 // aligned two lines
0095_0c
00a2_02
00bf_01
1234_09
7ffd_06
fffe_05 // wraps past the top of the address space
0100_0f
0203_0e
0300_10
0401_0f

/* filelist.f */
+incdir+include
source/burst_bridge_pkg.sv
source/burst_aligner.sv
source/pending_read_fifo.sv
source/read_response_filter.sv
source/unaligned_burst_bridge.sv
tests/unaligned_burst_bridge_sva.sv
tests/tb_unaligned_burst_bridge.sv

/* Bender.yml */
package:
  name: unaligned_burst_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/burst_bridge_pkg.sv
      - source/burst_aligner.sv
      - source/pending_read_fifo.sv
      - source/read_response_filter.sv
      - source/unaligned_burst_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/unaligned_burst_bridge_sva.sv
      - tests/tb_unaligned_burst_bridge.sv
